// ==== src/burst_bus_config.svh ====
`ifndef BURST_BUS_CONFIG_SVH
`define BURST_BUS_CONFIG_SVH

// Byte address of burst register 0
`define BURST_REG_BASE_ADDR 32'h10002020

// Size of the burst register block
`define BURST_REG_COUNT 6

// Holds the byte offset applied to burst reads
`define BURST_OFFSET_REG 5

// SRAM size in 32-bit words
`define SRAM_DEPTH_WORDS 1024

// Start value of the stall LFSR, must be nonzero
`define SRAM_STALL_SEED 8'hA5

`endif

// ==== src/burst_bus_pkg.sv ====
`default_nettype none

package burst_bus_pkg;

    // One data word on the CPU port and on Wishbone
    typedef logic [31:0] word_t;

    // Word address, byte address bits 31 down to 2
    typedef logic [31:2] word_adr_t;

    // Byte strobes / Wishbone select
    typedef logic [3:0] byte_sel_t;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_SINGLE = 2'd1,
        ST_BURST  = 2'd2,
        ST_LOCAL  = 2'd3
    } bridge_state_e;

endpackage

`default_nettype wire

// ==== src/picorv_burst_fsm.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "burst_bus_config.svh"

module picorv_burst_fsm (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       picorv_valid_i,
    input  wire burst_bus_pkg::word_adr_t picorv_addr_i,
    input  wire burst_bus_pkg::word_t picorv_wdata_i,
    input  wire burst_bus_pkg::byte_sel_t picorv_wstrb_i,
    output logic                      picorv_rdy_o,
    output burst_bus_pkg::word_t      picorv_rdata_o,

    output burst_bus_pkg::word_adr_t  wbm_adr_o,
    output burst_bus_pkg::word_t      wbm_dat_o,
    output logic                      wbm_we_o,
    output burst_bus_pkg::byte_sel_t  wbm_sel_o,
    output logic                      wbm_stb_o,
    output logic                      wbm_cyc_o,
    input  wire burst_bus_pkg::word_t wbm_dat_i,
    input  wire                       wbm_ack_i,
    input  wire                       wbm_stall_i,
    input  wire                       wbm_err_i
);

    localparam burst_bus_pkg::word_adr_t BURST_BASE_WORD = 30'(`BURST_REG_BASE_ADDR >> 2);

    burst_bus_pkg::bridge_state_e state;
    burst_bus_pkg::word_t     burst_reg [0:`BURST_REG_COUNT-1];
    burst_bus_pkg::word_adr_t req_adr_q;   // Word address of the pending request, bit 31 cleared
    burst_bus_pkg::byte_sel_t req_sel_q;   // Strobes of the pending request
    logic [1:0]               beat_q;
    logic                     stb_q;
    logic                     cyc_q;
    logic                     burst_rdy_q;

    logic                     in_local;
    logic                     req_write;
    logic                     beat_done;
    burst_bus_pkg::word_adr_t local_off;
    logic [2:0]               local_idx;
    logic [2:0]               beat_idx;
    logic [2:0]               beat_idx_hi;
    logic [1:0]               offset;
    burst_bus_pkg::word_t     local_wmask;
    logic [63:0]              splice_old;
    logic [63:0]              splice_mask;
    logic [63:0]              splice_new;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode and burst read splice
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign req_write = |picorv_wstrb_i;
    assign in_local  = (picorv_addr_i >= BURST_BASE_WORD) &&
                       (picorv_addr_i < BURST_BASE_WORD + 30'(`BURST_REG_COUNT));
    assign local_off = picorv_addr_i - BURST_BASE_WORD;
    assign local_idx = local_off[4:2];
    assign beat_done = wbm_ack_i | wbm_err_i;   // Err ends the beat, nothing more

    assign beat_idx    = {1'b0, beat_q};
    assign beat_idx_hi = beat_idx + 3'd1;
    assign offset      = burst_reg[`BURST_OFFSET_REG][1:0];

    // Returned word lands k bytes up across registers n and n+1
    assign splice_old  = {burst_reg[beat_idx_hi], burst_reg[beat_idx]};
    assign splice_mask = {32'h0000_0000, 32'hffff_ffff} << {offset, 3'b000};
    assign splice_new  = (splice_old & ~splice_mask) |
                         ({32'h0000_0000, wbm_dat_i} << {offset, 3'b000});

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            local_wmask[8*i +: 8] = {8{picorv_wstrb_i[i]}};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        picorv_rdy_o   = 1'b0;
        picorv_rdata_o = '0;
        wbm_adr_o      = req_adr_q;
        wbm_dat_o      = picorv_wdata_i;
        wbm_we_o       = |req_sel_q;
        wbm_sel_o      = (|req_sel_q) ? req_sel_q : 4'b1111;
        wbm_stb_o      = stb_q;
        wbm_cyc_o      = cyc_q;
        case (state)
            burst_bus_pkg::ST_IDLE: begin
                // First single beat goes out in the same cycle
                wbm_adr_o = {1'b0, picorv_addr_i[30:2]};
                wbm_we_o  = req_write;
                wbm_sel_o = req_write ? picorv_wstrb_i : 4'b1111;
                wbm_stb_o = picorv_valid_i && !in_local && !picorv_addr_i[31];
                wbm_cyc_o = picorv_valid_i && !in_local && !picorv_addr_i[31];
            end
            burst_bus_pkg::ST_SINGLE: begin
                picorv_rdy_o   = beat_done;
                picorv_rdata_o = wbm_dat_i;
            end
            burst_bus_pkg::ST_BURST: begin
                picorv_rdy_o = burst_rdy_q;      // CPU released on entry
                wbm_adr_o    = req_adr_q + 30'(beat_q);
                wbm_dat_o    = burst_reg[beat_idx];
            end
            burst_bus_pkg::ST_LOCAL: begin
                picorv_rdy_o   = 1'b1;
                picorv_rdata_o = burst_reg[local_idx];
                wbm_adr_o      = '0;
                wbm_dat_o      = '0;
                wbm_we_o       = 1'b0;
                wbm_sel_o      = '0;
            end
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= burst_bus_pkg::ST_IDLE;
            beat_q      <= 2'd0;
            stb_q       <= 1'b0;
            cyc_q       <= 1'b0;
            burst_rdy_q <= 1'b0;
            for (int i = 0; i < `BURST_REG_COUNT; i++) begin
                burst_reg[i] <= '0;
            end
        end else begin
            case (state)
                burst_bus_pkg::ST_IDLE: begin
                    if (picorv_valid_i && in_local) begin
                        if (req_write) begin
                            burst_reg[local_idx] <= (burst_reg[local_idx] & ~local_wmask) |
                                                    (picorv_wdata_i & local_wmask);
                        end
                        state <= burst_bus_pkg::ST_LOCAL;
                    end else if (picorv_valid_i) begin
                        req_adr_q <= {1'b0, picorv_addr_i[30:2]};
                        req_sel_q <= picorv_wstrb_i;
                        cyc_q     <= 1'b1;
                        beat_q    <= 2'd0;
                        if (picorv_addr_i[31]) begin
                            // Carry the spill-over of the last unaligned read
                            if (!req_write) begin
                                burst_reg[0] <= burst_reg[4];
                            end
                            stb_q       <= 1'b1;
                            burst_rdy_q <= 1'b1;
                            state       <= burst_bus_pkg::ST_BURST;
                        end else begin
                            stb_q <= wbm_stall_i;   // Still owed if stalled here
                            state <= burst_bus_pkg::ST_SINGLE;
                        end
                    end
                end
                burst_bus_pkg::ST_SINGLE: begin
                    if (stb_q && !wbm_stall_i) begin
                        stb_q <= 1'b0;
                    end
                    if (beat_done) begin
                        cyc_q <= 1'b0;
                        state <= burst_bus_pkg::ST_IDLE;
                    end
                end
                burst_bus_pkg::ST_BURST: begin
                    burst_rdy_q <= 1'b0;
                    if (stb_q && !wbm_stall_i) begin
                        stb_q <= 1'b0;
                    end
                    if (beat_done) begin
                        if (!(|req_sel_q)) begin
                            burst_reg[beat_idx]    <= splice_new[31:0];
                            burst_reg[beat_idx_hi] <= splice_new[63:32];
                        end
                        if (beat_q == 2'd3) begin
                            cyc_q <= 1'b0;
                            state <= burst_bus_pkg::ST_IDLE;
                        end else begin
                            beat_q <= beat_q + 2'd1;
                            stb_q  <= 1'b1;
                        end
                    end
                end
                burst_bus_pkg::ST_LOCAL: begin
                    state <= burst_bus_pkg::ST_IDLE;   // Lets valid fall
                end
                default: state <= burst_bus_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/wb_sram.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "burst_bus_config.svh"

module wb_sram (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           wbs_cyc_i,
    input  wire                           wbs_stb_i,
    input  wire                           wbs_we_i,
    input  wire burst_bus_pkg::word_adr_t wbs_adr_i,
    input  wire burst_bus_pkg::word_t     wbs_dat_i,
    input  wire burst_bus_pkg::byte_sel_t wbs_sel_i,
    output burst_bus_pkg::word_t          wbs_dat_o,
    output logic                          wbs_ack_o,
    output logic                          wbs_err_o,
    output logic                          wbs_stall_o
);

    localparam int ADR_BITS = $clog2(`SRAM_DEPTH_WORDS);

    burst_bus_pkg::word_t mem [0:`SRAM_DEPTH_WORDS-1];
    logic [7:0]           lfsr;
    logic                 accept;
    logic                 in_range;
    logic [ADR_BITS-1:0]  mem_idx;

    assign wbs_stall_o = lfsr[0];
    assign accept      = wbs_cyc_i && wbs_stb_i && !lfsr[0];
    assign in_range    = wbs_adr_i < `SRAM_DEPTH_WORDS;
    assign mem_idx     = wbs_adr_i[ADR_BITS+1:2];

    // x^8 + x^6 + x^5 + x^4 + 1, runs every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= `SRAM_STALL_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbs_ack_o <= 1'b0;
            wbs_err_o <= 1'b0;
        end else begin
            wbs_ack_o <= accept && in_range;
            wbs_err_o <= accept && !in_range;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (accept) begin
            if (in_range) begin
                wbs_dat_o <= mem[mem_idx];   // Old contents on a write
                if (wbs_we_i) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wbs_sel_i[i]) begin
                            mem[mem_idx][8*i +: 8] <= wbs_dat_i[8*i +: 8];
                        end
                    end
                end
            end else begin
                wbs_dat_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/burst_bus_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module burst_bus_top (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           picorv_valid_i,
    input  wire burst_bus_pkg::word_adr_t picorv_addr_i,
    input  wire burst_bus_pkg::word_t     picorv_wdata_i,
    input  wire burst_bus_pkg::byte_sel_t picorv_wstrb_i,
    output wire                           picorv_rdy_o,
    output wire burst_bus_pkg::word_t     picorv_rdata_o
);

    // Pipelined Wishbone between bridge and memory
    wire burst_bus_pkg::word_adr_t wb_adr;
    wire burst_bus_pkg::word_t     wb_dat_w;
    wire burst_bus_pkg::word_t     wb_dat_r;
    wire burst_bus_pkg::byte_sel_t wb_sel;
    wire                           wb_we;
    wire                           wb_stb;
    wire                           wb_cyc;
    wire                           wb_ack;
    wire                           wb_stall;
    wire                           wb_err;

    picorv_burst_fsm picorv_burst_fsm_inst (
        .clk            (clk),
        .rst            (rst),
        .picorv_valid_i (picorv_valid_i),
        .picorv_addr_i  (picorv_addr_i),
        .picorv_wdata_i (picorv_wdata_i),
        .picorv_wstrb_i (picorv_wstrb_i),
        .picorv_rdy_o   (picorv_rdy_o),
        .picorv_rdata_o (picorv_rdata_o),
        .wbm_adr_o      (wb_adr),
        .wbm_dat_o      (wb_dat_w),
        .wbm_we_o       (wb_we),
        .wbm_sel_o      (wb_sel),
        .wbm_stb_o      (wb_stb),
        .wbm_cyc_o      (wb_cyc),
        .wbm_dat_i      (wb_dat_r),
        .wbm_ack_i      (wb_ack),
        .wbm_stall_i    (wb_stall),
        .wbm_err_i      (wb_err)
    );

    wb_sram wb_sram_inst (
        .clk         (clk),
        .rst         (rst),
        .wbs_cyc_i   (wb_cyc),
        .wbs_stb_i   (wb_stb),
        .wbs_we_i    (wb_we),
        .wbs_adr_i   (wb_adr),
        .wbs_dat_i   (wb_dat_w),
        .wbs_sel_i   (wb_sel),
        .wbs_dat_o   (wb_dat_r),
        .wbs_ack_o   (wb_ack),
        .wbs_err_o   (wb_err),
        .wbs_stall_o (wb_stall)
    );

endmodule

`default_nettype wire

// ==== verification/burst_bus_tb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "burst_bus_config.svh"

module burst_bus_tb;

    localparam int MAX_WAIT = 200;   // Cycles allowed for picorv_rdy_o

    logic                     clk;
    logic                     rst;
    logic                     picorv_valid;
    burst_bus_pkg::word_adr_t picorv_addr;
    burst_bus_pkg::word_t     picorv_wdata;
    burst_bus_pkg::byte_sel_t picorv_wstrb;
    wire                      picorv_rdy;
    wire burst_bus_pkg::word_t picorv_rdata;

    int error_count;
    int timeout_count;
    int check_count;

    burst_bus_top burst_bus_top_inst (
        .clk            (clk),
        .rst            (rst),
        .picorv_valid_i (picorv_valid),
        .picorv_addr_i  (picorv_addr),
        .picorv_wdata_i (picorv_wdata),
        .picorv_wstrb_i (picorv_wstrb),
        .picorv_rdy_o   (picorv_rdy),
        .picorv_rdata_o (picorv_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    // Names the kind of access for timeout messages
    function automatic string access_kind(input logic [31:0] byte_addr);
        logic [31:0] local_end;
        local_end = `BURST_REG_BASE_ADDR + 4 * `BURST_REG_COUNT;
        if (byte_addr == `BURST_REG_BASE_ADDR + 4 * `BURST_OFFSET_REG) begin
            return "offset register";
        end else if (byte_addr >= `BURST_REG_BASE_ADDR && byte_addr < local_end) begin
            return "local";
        end else if (byte_addr[31]) begin
            return "burst";
        end else if (byte_addr[31:2] >= `SRAM_DEPTH_WORDS) begin
            return "out-of-range single";
        end
        return "single";
    endfunction

    // One CPU transaction: drive on the falling edge, hold until ready
    task automatic cpu_request(input logic [31:0] byte_addr, input burst_bus_pkg::word_t wdata,
                               input burst_bus_pkg::byte_sel_t wstrb,
                               output burst_bus_pkg::word_t rdata, output bit done);
        int waited;
        done   = 1'b0;
        rdata  = '0;
        waited = 0;
        @(negedge clk);
        picorv_valid = 1'b1;
        picorv_addr  = byte_addr[31:2];
        picorv_wdata = wdata;
        picorv_wstrb = wstrb;
        while (!done && waited < MAX_WAIT) begin
            @(negedge clk);
            waited++;
            if (picorv_rdy) begin
                done  = 1'b1;
                rdata = picorv_rdata;   // Stable half a cycle before the handshake edge
            end
        end
        if (!done) begin
            timeout_count++;
            $display("Timeout: no ready within %0d cycles for %s access at 0x%08h",
                     MAX_WAIT, access_kind(byte_addr), byte_addr);
        end
        @(negedge clk);
        picorv_valid = 1'b0;
        picorv_wstrb = '0;
    endtask

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("picorv_rdy_o", picorv_rdy, 32'd0);
        end
    endtask

    task automatic run_line(input logic [7:0] op, input logic [31:0] byte_addr,
                            input burst_bus_pkg::word_t wdata,
                            input burst_bus_pkg::byte_sel_t wstrb,
                            input burst_bus_pkg::word_t expected);
        burst_bus_pkg::word_t rdata;
        bit                   done;
        case (op)
            "I": idle_check(wdata);   // Cycle count in the data column
            "W": cpu_request(byte_addr, wdata, wstrb, rdata, done);
            "B": cpu_request(byte_addr, '0, 4'h0, rdata, done);
            "R": begin
                cpu_request(byte_addr, '0, 4'h0, rdata, done);
                if (done) begin
                    check_value($sformatf("picorv_rdata_o @ 0x%08h", byte_addr), rdata, expected);
                end
            end
            default: begin
                error_count++;
                $display("Unknown operation '%c' in the stimulus file", op);
            end
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : main
        int                        fd;
        int                        rc;
        int                        ch;
        bit                        stop;
        logic [7:0]                op;
        logic [31:0]               byte_addr;
        burst_bus_pkg::word_t      wdata;
        burst_bus_pkg::byte_sel_t  wstrb;
        burst_bus_pkg::word_t      expected;

        error_count   = 0;
        timeout_count = 0;
        check_count   = 0;
        rst           = 1'b1;
        picorv_valid  = 1'b0;
        picorv_addr   = '0;
        picorv_wdata  = '0;
        picorv_wstrb  = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("verification/burst_bus_stim.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open verification/burst_bus_stim.txt");
        end else begin
            stop = 1'b0;
            while (!stop) begin
                rc = $fscanf(fd, " %c", op);
                if (rc != 1) begin
                    stop = 1'b1;
                end else if (op == "#") begin
                    ch = $fgetc(fd);   // Skip the rest of a comment line
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    rc = $fscanf(fd, "%h %h %h %h", byte_addr, wdata, wstrb, expected);
                    if (rc != 4) begin
                        error_count++;
                        $display("Stimulus line starting with '%c' could not be parsed", op);
                        stop = 1'b1;
                    end else begin
                        run_line(op, byte_addr, wdata, wstrb, expected);
                    end
                end
            end
            $fclose(fd);
        end

        repeat (2) @(negedge clk);
        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+src
src/burst_bus_pkg.sv
src/picorv_burst_fsm.sv
src/wb_sram.sv
src/burst_bus_top.sv
verification/burst_bus_tb.sv

// ==== verification/burst_bus_stim.txt ====
# op byte_addr wdata strobes expected_rdata
# I = idle cycles given in wdata, W = write, R = read and compare, B = burst read
I 00000000 00000005 0 00000000
R 10002020 00000000 0 00000000
R 10002024 00000000 0 00000000
R 10002028 00000000 0 00000000
R 1000202c 00000000 0 00000000
R 10002030 00000000 0 00000000
R 10002034 00000000 0 00000000
# Single writes, full then partial strobes
W 00000000 11223344 f 00000000
W 00000004 55667788 f 00000000
W 00000008 99aabbcc f 00000000
W 0000000c deadbeef f 00000000
W 00000000 cafef00d 9 00000000
W 00000004 a5a5a5a5 1 00000000
W 00000008 0f0f0f0f 6 00000000
W 0000000c 12345678 c 00000000
R 00000000 00000000 0 ca22330d
R 00000004 00000000 0 556677a5
R 00000008 00000000 0 990f0fcc
R 0000000c 00000000 0 1234beef
# Burst registers 0 to 5
W 10002020 01234567 f 00000000
W 10002024 89abcdef f 00000000
W 10002028 fedcba98 f 00000000
W 1000202c 76543210 f 00000000
W 10002030 ffb2c3d4 f 00000000
W 10002034 0000ff00 f 00000000
R 10002020 00000000 0 01234567
R 10002024 00000000 0 89abcdef
R 10002028 00000000 0 fedcba98
R 1000202c 00000000 0 76543210
R 10002030 00000000 0 ffb2c3d4
R 10002034 00000000 0 0000ff00
# Burst write of registers 0 to 3 to words 0x40 to 0x43
W 80000100 00000000 f 00000000
R 00000100 00000000 0 01234567
R 00000104 00000000 0 89abcdef
R 00000108 00000000 0 fedcba98
R 0000010c 00000000 0 76543210
# Burst reads with offsets 0 to 3
B 80000000 00000000 0 00000000
R 10002020 00000000 0 ca22330d
R 10002024 00000000 0 556677a5
R 10002028 00000000 0 990f0fcc
R 1000202c 00000000 0 1234beef
R 10002030 00000000 0 ffb2c3d4
W 10002034 00000001 f 00000000
B 80000100 00000000 0 00000000
R 10002020 00000000 0 234567d4
R 10002024 00000000 0 abcdef01
R 10002028 00000000 0 dcba9889
R 1000202c 00000000 0 543210fe
R 10002030 00000000 0 ffb2c376
W 10002034 00000002 f 00000000
B 80000000 00000000 0 00000000
R 10002020 00000000 0 330dc376
R 10002024 00000000 0 77a5ca22
R 10002028 00000000 0 0fcc5566
R 1000202c 00000000 0 beef990f
R 10002030 00000000 0 ffb21234
W 10002034 00000003 f 00000000
B 80000100 00000000 0 00000000
R 10002020 00000000 0 67b21234
R 10002024 00000000 0 ef012345
R 10002028 00000000 0 9889abcd
R 1000202c 00000000 0 10fedcba
R 10002030 00000000 0 ff765432
# Beyond the SRAM depth, then the earlier words again
R 00001000 00000000 0 00000000
W 00001000 deadbeef f 00000000
R 00000000 00000000 0 ca22330d
R 00000004 00000000 0 556677a5
R 00000008 00000000 0 990f0fcc
R 0000000c 00000000 0 1234beef
